//--- logic/wr_path_pkg.sv
package wr_path_pkg;

  // memory side address width
  // one beat address, byte granular
  localparam int addr_w = 32;

  // data word carried by each beat
  // matches the outbuf word width
  localparam int data_w = 64;

  // beat count field of a macro request
  // a count of zero is legal and issues nothing
  localparam int beats_w = 10;

  // address step between consecutive beats
  // one data word is eight bytes
  localparam int beat_bytes = data_w / 8;

  // default depth of the macro request queue
  localparam int macro_q_depth_default = 4;

  // default depth of the memory request queue
  // absorbs grant back-pressure before the sequencer stalls
  localparam int req_q_depth_default = 8;

  // one queued macro write request
  // start address plus the number of beats to issue
  typedef struct packed {
    logic [addr_w-1:0]  addr;
    logic [beats_w-1:0] beats;
  } macro_req_t;

  // one memory write beat
  // size and direction are implied by this package
  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
  } mem_req_t;

endpackage

//--- logic/sync_fifo.sv
`timescale 1ns/100ps

module sync_fifo #(
  parameter type payload_t = logic,
  parameter int  depth     = 4
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t head,
  output logic     empty,
  output logic     full
);

  // pointer needs at least one bit even for a single entry
  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  // occupancy runs from 0 up to depth inclusive
  localparam int cnt_w = $clog2(depth + 1);
  // highest slot index, pointers wrap after it
  localparam logic [ptr_w-1:0] last_slot = ptr_w'(depth - 1);

  // circular storage
  payload_t mem [depth];

  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             push_ok;
  logic             pop_ok;

  // step a pointer with wrap for any depth
  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    logic [ptr_w-1:0] nxt;
    if (ptr == last_slot) begin
      nxt = '0;
    end else begin
      nxt = ptr + ptr_w'(1);
    end
    return nxt;
  endfunction

  // status from occupancy
  assign empty = (count == '0);
  assign full  = (count == cnt_w'(depth));

  // drop push when full, drop pop when empty
  assign push_ok = push && !full;
  assign pop_ok  = pop && !empty;

  // show-ahead head, valid whenever not empty
  assign head = mem[rd_ptr];

  // storage write, no reset on payload
  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop_ok) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // simultaneous push and pop leaves count alone
      case ({push_ok, pop_ok})
        2'b10:   count <= count + cnt_w'(1);
        2'b01:   count <= count - cnt_w'(1);
        default: count <= count;
      endcase
    end
  end

endmodule

//--- logic/burst_sequencer.sv
`timescale 1ns/100ps

module burst_sequencer (
  input  logic                           clk,
  input  logic                           rst,
  // macro request queue side
  input  logic                           macro_empty,
  input  wr_path_pkg::macro_req_t        macro_head,
  output logic                           macro_pop,
  // output buffer side, data shown ahead
  input  logic                           outbuf_empty,
  input  logic [wr_path_pkg::data_w-1:0] outbuf_data,
  output logic                           outbuf_pop,
  // memory request queue side
  input  logic                           req_full,
  output logic                           req_push,
  output wr_path_pkg::mem_req_t          req_data,
  // status
  output logic                           busy,
  output logic                           wr_done
);

  import wr_path_pkg::*;

  // a macro request is being split into beats
  logic               active;
  // address of the next beat to issue
  logic [addr_w-1:0]  cur_addr;
  // beats still to issue for the active request
  logic [beats_w-1:0] beats_left;

  logic               load;
  logic               issue;
  logic               last_beat;
  logic               finish;

  // idle with work waiting, take the queue head
  assign load      = !active && !macro_empty;
  assign macro_pop = load;

  // one beat per cycle when data is there and the queue has room
  assign issue = active && (beats_left != '0) && !outbuf_empty && !req_full;

  // beat consumes the outbuf word in the same cycle
  assign outbuf_pop = issue;
  assign req_push   = issue;

  assign last_beat = (beats_left == beats_w'(1));

  // request ends on its last beat
  // or right away when it carried no beats at all
  assign finish = active && ((beats_left == '0) || (issue && last_beat));

  // beat payload
  // current address paired with the outbuf head
  always_comb begin
    req_data      = '0;
    req_data.addr = cur_addr;
    req_data.data = outbuf_data;
  end

  // top level needs this for wr_ready
  assign busy = active;

  // control state
  always_ff @(posedge clk) begin
    if (rst) begin
      active     <= 1'b0;
      beats_left <= '0;
      wr_done    <= 1'b0;
    end else begin
      // done pulse one cycle after the finishing cycle
      wr_done <= finish;

      if (load) begin
        active     <= 1'b1;
        beats_left <= macro_head.beats;
      end else begin
        if (finish) begin
          active <= 1'b0;
        end
        // count down per issued beat
        if (issue) begin
          beats_left <= beats_left - beats_w'(1);
        end
      end
    end
  end

  // address register
  // loaded from the queue head, stepped per beat
  always_ff @(posedge clk) begin
    if (load) begin
      cur_addr <= macro_head.addr;
    end else if (issue) begin
      cur_addr <= cur_addr + addr_w'(beat_bytes);
    end
  end

endmodule

//--- logic/wr_path_top.sv
`timescale 1ns/100ps

module wr_path_top #(
  parameter int macro_q_depth = wr_path_pkg::macro_q_depth_default,
  parameter int req_q_depth   = wr_path_pkg::req_q_depth_default
) (
  input  logic                            clk,
  input  logic                            rst,
  // macro write request from the producer
  input  logic                            wr_req,
  input  logic [wr_path_pkg::addr_w-1:0]  wr_addr,
  input  logic [wr_path_pkg::beats_w-1:0] wr_beats,
  output logic                            wr_ready,
  output logic                            wr_done,
  // output buffer
  input  logic                            outbuf_empty,
  input  logic [wr_path_pkg::data_w-1:0]  outbuf_data,
  output logic                            outbuf_pop,
  // memory system, valid/grant
  output logic                            mem_req_valid,
  output wr_path_pkg::mem_req_t           mem_req,
  input  logic                            mem_req_grant
);

  import wr_path_pkg::*;

  macro_req_t macro_in;
  macro_req_t macro_head;
  logic       macro_push;
  logic       macro_pop;
  logic       macro_empty;
  logic       macro_full;

  mem_req_t   req_data;
  logic       req_push;
  logic       req_pop;
  logic       req_empty;
  logic       req_full;

  logic       seq_busy;

  // pack the strobed request
  assign macro_in.addr  = wr_addr;
  assign macro_in.beats = wr_beats;

  // strobe while full is lost
  assign macro_push = wr_req && !macro_full;

  // macro request queue
  sync_fifo #(
    .payload_t (macro_req_t),
    .depth     (macro_q_depth)
  ) u_macro_q (
    .clk       (clk),
    .rst       (rst),
    .push      (macro_push),
    .push_data (macro_in),
    .pop       (macro_pop),
    .head      (macro_head),
    .empty     (macro_empty),
    .full      (macro_full)
  );

  // splits macro requests into beats
  burst_sequencer u_seq (
    .clk          (clk),
    .rst          (rst),
    .macro_empty  (macro_empty),
    .macro_head   (macro_head),
    .macro_pop    (macro_pop),
    .outbuf_empty (outbuf_empty),
    .outbuf_data  (outbuf_data),
    .outbuf_pop   (outbuf_pop),
    .req_full     (req_full),
    .req_push     (req_push),
    .req_data     (req_data),
    .busy         (seq_busy),
    .wr_done      (wr_done)
  );

  // memory request queue, head drives the bus directly
  sync_fifo #(
    .payload_t (mem_req_t),
    .depth     (req_q_depth)
  ) u_req_q (
    .clk       (clk),
    .rst       (rst),
    .push      (req_push),
    .push_data (req_data),
    .pop       (req_pop),
    .head      (mem_req),
    .empty     (req_empty),
    .full      (req_full)
  );

  // head advances only on a granted beat
  assign mem_req_valid = !req_empty;
  assign req_pop       = mem_req_valid && mem_req_grant;

  // whole path drained
  assign wr_ready = macro_empty && !seq_busy && req_empty;

endmodule

//--- bench/wr_path_cases.svh
`ifndef WR_PATH_CASES_SVH
`define WR_PATH_CASES_SVH

// columns: start address, beat count, outbuf data seed, grant mode
// zero-beat rows issue nothing but still pulse wr_done
// the wrap row crosses the top of the address space
case_t case_tab [num_cases] = '{
  '{32'h0000_1000, 10'd4,  32'h1111_0001, grant_always},
  '{32'h0000_2000, 10'd1,  32'h2222_0002, grant_always},
  '{32'h0000_3000, 10'd0,  32'h3333_0003, grant_always},
  // long burst under random grant
  '{32'h0001_0000, 10'd16, 32'h4444_0004, grant_random},
  // grant held low, fills the request queue
  '{32'h0002_0008, 10'd12, 32'h5555_0005, grant_hold},
  '{32'hffff_ffc0, 10'd10, 32'h6666_0006, grant_random},
  '{32'h0000_4000, 10'd0,  32'h7777_0007, grant_hold},
  '{32'h0003_0000, 10'd24, 32'h8888_0008, grant_hold},
  '{32'h0000_5000, 10'd3,  32'h9999_0009, grant_random},
  '{32'h0004_0000, 10'd40, 32'haaaa_000a, grant_always}
};

`endif

//--- bench/wr_path_tb.sv
`timescale 1ns/100ps

module wr_path_tb;

  import wr_path_pkg::*;

  // grant behaviour per case
  localparam logic [1:0] grant_always = 2'd0;
  localparam logic [1:0] grant_random = 2'd1;
  localparam logic [1:0] grant_hold   = 2'd2;
  localparam int hold_cycles = 20;
  localparam int num_cases   = 10;
  localparam int timeout_cycles = 4000;

  // one stimulus row
  typedef struct packed {
    logic [addr_w-1:0]  addr;
    logic [beats_w-1:0] beats;
    logic [31:0]        seed;
    logic [1:0]         mode;
  } case_t;

  `include "wr_path_cases.svh"

  logic               clk;
  logic               rst;
  logic               wr_req;
  logic [addr_w-1:0]  wr_addr;
  logic [beats_w-1:0] wr_beats;
  logic               wr_ready;
  logic               wr_done;
  logic               outbuf_empty;
  logic [data_w-1:0]  outbuf_data;
  logic               outbuf_pop;
  logic               mem_req_valid;
  mem_req_t           mem_req;
  logic               mem_req_grant;

  // request in flight as seen by the models
  logic [addr_w-1:0]  cur_addr;
  logic [beats_w-1:0] cur_beats;
  logic [31:0]        cur_seed;
  logic [1:0]         cur_mode;

  int       val_errs;
  int       other_errs;
  int       beat_cnt;
  int       pop_cnt;
  int       done_cnt;
  int       ob_idx;
  int       idx_n;
  int       hold_left;
  int       hold_n;
  int       waited;
  int       seed_val;
  logic     req_open;
  logic     strobe_d;
  logic     pop_seen;
  logic     prev_valid;
  logic     prev_grant;
  mem_req_t prev_req;
  mem_req_t exp_req;

  wr_path_top u_dut (
    .clk           (clk),
    .rst           (rst),
    .wr_req        (wr_req),
    .wr_addr       (wr_addr),
    .wr_beats      (wr_beats),
    .wr_ready      (wr_ready),
    .wr_done       (wr_done),
    .outbuf_empty  (outbuf_empty),
    .outbuf_data   (outbuf_data),
    .outbuf_pop    (outbuf_pop),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .mem_req_grant (mem_req_grant)
  );

  always #20 clk = ~clk;

  // i-th outbuf word of a request
  function automatic logic [data_w-1:0] outbuf_word(input logic [31:0] seed, input int idx);
    logic [31:0] i32;
    i32 = 32'(idx);
    return {seed ^ (i32 * 32'h9e37_79b9), seed + i32};
  endfunction

  task automatic check_mem_req(input string name, input mem_req_t got, input mem_req_t exp);
    if (got !== exp) begin
      val_errs++;
      $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      val_errs++;
      $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      val_errs++;
      $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  // outbuf model
  // word index restarts on each strobe
  // random gaps raise outbuf_empty
  always @(posedge clk) begin
    if (wr_req) begin
      idx_n = 0;
    end else if (pop_seen) begin
      idx_n = ob_idx + 1;
    end else begin
      idx_n = ob_idx;
    end
    ob_idx <= idx_n;
    outbuf_empty <= (idx_n >= int'(cur_beats)) || ($urandom % 4 == 0);
    outbuf_data <= outbuf_word(cur_seed, idx_n);
  end

  // grant driver
  always @(posedge clk) begin
    hold_n = hold_left;
    if (wr_req && cur_mode == grant_hold) begin
      hold_n = hold_cycles;
    end else if (hold_n != 0) begin
      hold_n = hold_n - 1;
    end
    hold_left <= hold_n;
    case (cur_mode)
      grant_random: mem_req_grant <= 1'($urandom % 2);
      grant_hold:   mem_req_grant <= (hold_n == 0);
      default:      mem_req_grant <= 1'b1;
    endcase
  end

  // monitor samples mid-cycle
  always @(negedge clk) begin
    pop_seen = outbuf_pop;
    if (!rst) begin
      // stalled beat must hold
      if (prev_valid && !prev_grant) begin
        check_bit("mem_req_valid", mem_req_valid, 1'b1);
        check_mem_req("mem_req", mem_req, prev_req);
      end
      if (mem_req_valid && mem_req_grant) begin
        if (beat_cnt >= pop_cnt || beat_cnt >= int'(cur_beats)) begin
          other_errs++;
          $display("beat %0d transferred with no matching outbuf pop", beat_cnt);
        end else begin
          exp_req.addr = cur_addr + addr_w'(beat_cnt * beat_bytes);
          exp_req.data = outbuf_word(cur_seed, beat_cnt);
          check_mem_req("mem_req", mem_req, exp_req);
        end
        beat_cnt++;
      end
      // a pulse outside an open request is spurious
      if (wr_done) begin
        if (req_open) begin
          done_cnt++;
          check_count("outbuf pops at wr_done", pop_cnt, int'(cur_beats));
        end else begin
          other_errs++;
          $display("wr_done pulsed while no request was open");
        end
      end
      // popping an empty outbuf is an error
      if (outbuf_empty) begin
        check_bit("outbuf_pop", outbuf_pop, 1'b0);
      end
      if (outbuf_pop) begin
        pop_cnt++;
      end
      if (strobe_d) begin
        check_bit("wr_ready", wr_ready, 1'b0);
      end else if (req_open && wr_ready) begin
        check_count("beats granted at wr_ready", beat_cnt, int'(cur_beats));
        req_open = 1'b0;
      end
      strobe_d = wr_req;
      if (wr_req) begin
        req_open = 1'b1;
        beat_cnt = 0;
        pop_cnt  = 0;
        done_cnt = 0;
      end
      prev_valid = mem_req_valid;
      prev_grant = mem_req_grant;
      prev_req   = mem_req;
    end
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    wr_req = 1'b0;
    wr_addr = '0;
    wr_beats = '0;
    outbuf_empty = 1'b1;
    outbuf_data = '0;
    mem_req_grant = 1'b0;
    cur_addr = '0;
    cur_beats = '0;
    cur_seed = '0;
    cur_mode = grant_always;
    val_errs = 0;
    other_errs = 0;
    beat_cnt = 0;
    pop_cnt = 0;
    done_cnt = 0;
    ob_idx = 0;
    hold_left = 0;
    req_open = 1'b0;
    strobe_d = 1'b0;
    pop_seen = 1'b0;
    prev_valid = 1'b0;
    prev_grant = 1'b0;
    seed_val = 70;
    void'($urandom(seed_val));
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    // idle state straight out of reset
    @(negedge clk);
    check_bit("wr_ready", wr_ready, 1'b1);
    check_bit("mem_req_valid", mem_req_valid, 1'b0);
    check_bit("outbuf_pop", outbuf_pop, 1'b0);
    check_bit("wr_done", wr_done, 1'b0);
    @(posedge clk);
    for (int c = 0; c < num_cases; c++) begin
      // strobe the next macro request
      wr_req    <= 1'b1;
      wr_addr   <= case_tab[c].addr;
      wr_beats  <= case_tab[c].beats;
      cur_addr  <= case_tab[c].addr;
      cur_beats <= case_tab[c].beats;
      cur_seed  <= case_tab[c].seed;
      cur_mode  <= case_tab[c].mode;
      @(posedge clk);
      wr_req <= 1'b0;
      // wait until the monitor sees wr_ready back high
      waited = 0;
      while (req_open && waited < timeout_cycles) begin
        @(posedge clk);
        waited++;
      end
      if (req_open) begin
        other_errs++;
        $display("timeout waiting for wr_ready in case %0d", c);
        break;
      end
      check_count("wr_done pulses", done_cnt, 1);
      check_count("outbuf pops", pop_cnt, int'(case_tab[c].beats));
      check_count("beats granted", beat_cnt, int'(case_tab[c].beats));
    end
    repeat (5) @(posedge clk);
    $display("errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+bench
logic/wr_path_pkg.sv
logic/sync_fifo.sv
logic/burst_sequencer.sv
logic/wr_path_top.sv
bench/wr_path_tb.sv

//--- Bender.yml
package:
  name: wr_path

sources:
  - logic/wr_path_pkg.sv
  - logic/sync_fifo.sv
  - logic/burst_sequencer.sv
  - logic/wr_path_top.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/wr_path_tb.sv
